/* Bender.yml */
package:
  name: clio_ctrl

sources:
  - files:
      - hw/clio_pkg.sv
      - hw/spi_word_fifo.sv
      - hw/spi_word_master.sv
      - hw/spi_burst_ctrl.sv
      - hw/clio_reg_bank.sv
      - hw/clio_ctrl_top.sv
  - target: test
    files:
      - testbench/tb_clk_gen.sv
      - testbench/tb_clio_ctrl.sv

/* hw/clio_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none

module clio_ctrl_top #(
  parameter int FIFO_DEPTH_LOG2 = 6,
  parameter int SCLK_HALF       = 2,
  parameter int PACE_BITS       = 7,
  parameter int WORDS_PER_BURST = 4
) (
  input  wire                        ti_clk,
  input  wire                        adjust_reset,
  input  wire                        i_reg_ptr_clear,
  input  wire clio_pkg::pipe_in_t    i_reg_pipe,
  input  wire clio_pkg::pipe_in_t    i_noz_pipe,
  input  wire                        i_spi_miso,
  output wire clio_pkg::word_t       o_reg_rd_data,
  output wire clio_pkg::word_t       o_noz_rd_data,
  output wire clio_pkg::fifo_count_t o_noz_wr_count,
  output wire clio_pkg::fifo_count_t o_noz_rd_count,
  output wire                        o_spi_sclk,
  output wire                        o_spi_mosi,
  output wire                        o_spi_cs_n,
  output wire clio_pkg::supply_en_t  o_supply
);
  import clio_pkg::*;

  logic  shutdown;
  logic  burst_clear;
  logic  wr_empty;
  word_t wr_head;      // Next word for MOSI
  logic  start;
  logic  pop;
  logic  cs_n;
  reg_t  bursts;
  logic  busy;
  logic  rx_valid;
  word_t rx_word;

  clio_reg_bank reg_bank0 (
    .ti_clk        (ti_clk),
    .adjust_reset  (adjust_reset),
    .i_ptr_clear   (i_reg_ptr_clear),
    .i_pipe        (i_reg_pipe),
    .i_wr_count    (o_noz_wr_count),
    .i_rd_count    (o_noz_rd_count),
    .i_bursts      (bursts),
    .o_rd_data     (o_reg_rd_data),
    .o_shutdown    (shutdown),
    .o_burst_clear (burst_clear),
    .o_supply      (o_supply)
  );

  // Nozzle pipe to SPI
  spi_word_fifo #(.DEPTH_LOG2(FIFO_DEPTH_LOG2)) wr_fifo0 (
    .ti_clk       (ti_clk),
    .adjust_reset (adjust_reset),
    .i_push       (i_noz_pipe.wr),
    .i_push_data  (i_noz_pipe.data),
    .i_pop        (pop),
    .o_head       (wr_head),
    .o_empty      (wr_empty),
    .o_count      (o_noz_wr_count)
  );

  // SPI back to the nozzle read pipe
  spi_word_fifo #(.DEPTH_LOG2(FIFO_DEPTH_LOG2)) rd_fifo0 (
    .ti_clk       (ti_clk),
    .adjust_reset (adjust_reset),
    .i_push       (rx_valid),
    .i_push_data  (rx_word),
    .i_pop        (i_noz_pipe.rd),
    .o_head       (o_noz_rd_data),
    .o_empty      (),
    .o_count      (o_noz_rd_count)
  );

  spi_burst_ctrl #(
    .PACE_BITS       (PACE_BITS),
    .WORDS_PER_BURST (WORDS_PER_BURST)
  ) burst0 (
    .ti_clk        (ti_clk),
    .adjust_reset  (adjust_reset),
    .i_fifo_empty  (wr_empty),
    .i_master_busy (busy),
    .i_word_done   (rx_valid),
    .i_burst_clear (burst_clear),
    .o_start       (start),
    .o_pop         (pop),
    .o_cs_n        (cs_n),
    .o_bursts      (bursts)
  );

  spi_word_master #(.SCLK_HALF(SCLK_HALF)) master0 (
    .ti_clk       (ti_clk),
    .adjust_reset (adjust_reset),
    .i_start      (start),
    .i_tx_word    (wr_head),
    .i_spi_miso   (i_spi_miso),
    .i_cs_n       (cs_n),
    .i_shutdown   (shutdown),
    .o_busy       (busy),
    .o_rx_valid   (rx_valid),
    .o_rx_word    (rx_word),
    .o_spi_sclk   (o_spi_sclk),
    .o_spi_mosi   (o_spi_mosi),
    .o_spi_cs_n   (o_spi_cs_n)
  );

endmodule

`default_nettype wire

/* hw/clio_pkg.sv */
`default_nettype none

package clio_pkg;

  // ----------------------------------------
  // Widths with a meaning
  // ----------------------------------------
  typedef logic [15:0] word_t;        // Host pipe word, also one SPI word
  typedef logic [31:0] reg_t;         // One printing register
  typedef logic [9:0]  word_ptr_t;    // Word slot in register space, bit 0 picks the half
  typedef logic [6:0]  reg_idx_t;     // Register number, word_ptr_t bits 7:1
  typedef logic [15:0] fifo_count_t;  // Words held in a FIFO

  // One host pipe into the block, strobes last a single cycle per word
  typedef struct packed {
    logic  wr;    // Host hands over data
    logic  rd;    // Host has taken one word
    word_t data;
  } pipe_in_t;

  // CLIO supply enables
  typedef struct packed {
    logic vssn_en;     // -1.0V
    logic vss22n_en;   // -2.2V for the on-chip DACs
    logic vdd_en;      // 1.0V core, comes up first
    logic vdd15_en;    // 1.5V HSTL
    logic vdd22_en;    // 2.2V DACs
    logic vdd18_en_n;  // 1.8V HSTL, active low into a PMOS switch
    logic vtt_en;      // 0.75V HSTL termination
  } supply_en_t;

  typedef enum logic [1:0] {
    SPI_IDLE,
    SPI_SHIFT,
    SPI_TAIL
  } spi_state_e;

  // ----------------------------------------
  // Register map
  // ----------------------------------------
  localparam reg_idx_t REG_STATUS   = 7'd0;   // {rd count, wr count}, read only
  localparam reg_idx_t REG_CONTROL  = 7'd1;   // Bit 0 shutdown, bit 1 burst clear
  localparam reg_idx_t REG_VERSION  = 7'd2;   // Read only
  localparam reg_idx_t REG_LENGTH   = 7'd4;
  localparam reg_idx_t REG_DIVIDER  = 7'd6;
  localparam reg_idx_t REG_BURSTS   = 7'd7;   // Read only
  localparam reg_idx_t REG_SEGMENT1 = 7'd8;   // Waveform segments
  localparam reg_idx_t REG_SEGMENT2 = 7'd9;
  localparam reg_idx_t REG_SEGMENT3 = 7'd10;
  localparam reg_idx_t REG_SEGMENT4 = 7'd11;
  localparam reg_idx_t REG_SEGMENT5 = 7'd12;
  localparam reg_idx_t REG_SEGMENT6 = 7'd13;
  localparam reg_idx_t REG_SEGMENT7 = 7'd14;
  localparam reg_idx_t REG_SEGMENT8 = 7'd15;

  localparam reg_t FPGA_VERSION = 32'h0000_0304;
  localparam reg_t RD_DEFAULT   = 32'hDEAD_BEEF;  // Returned for unmapped reads
  localparam reg_t LENGTH_RST   = 32'd2250;       // Bytes per column
  localparam reg_t DIVIDER_RST  = 32'h0000_0020;

  // Five segment jetting waveform loaded at reset
  localparam reg_t SEGMENT_RST [8] = '{
    32'h3400_0071, 32'h0000_00A4, 32'hCC00_0071, 32'h0000_005A,
    32'h0000_0071, 32'h0000_0088, 32'h0000_0000, 32'h0000_0100
  };

endpackage

`default_nettype wire

/* hw/clio_reg_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module clio_reg_bank (
  input  wire                        ti_clk,
  input  wire                        adjust_reset,
  input  wire                        i_ptr_clear,   // Host trigger, restarts both pointers
  input  wire clio_pkg::pipe_in_t    i_pipe,
  input  wire clio_pkg::fifo_count_t i_wr_count,
  input  wire clio_pkg::fifo_count_t i_rd_count,
  input  wire clio_pkg::reg_t        i_bursts,
  output clio_pkg::word_t            o_rd_data,
  output logic                       o_shutdown,
  output logic                       o_burst_clear,
  output clio_pkg::supply_en_t       o_supply
);
  import clio_pkg::*;

  word_ptr_t w_ptr;          // Next slot the write pipe fills
  word_ptr_t r_ptr;          // Next slot the read pipe returns
  word_t     low_store;      // Low half parked until its high half arrives
  reg_t      control;
  reg_t      length;
  reg_t      divider;
  reg_t      segment [8];
  reg_t      rd_image;       // Register at r_ptr, refreshed every cycle
  logic      rd_half;        // r_ptr bit 0 lined up with rd_image
  reg_idx_t  wr_idx;
  reg_idx_t  rd_idx;
  reg_t      wr_value;
  logic      wr_commit;

  assign wr_idx    = w_ptr[7:1];
  assign rd_idx    = r_ptr[7:1];
  assign wr_value  = {i_pipe.data, low_store};
  assign wr_commit = i_pipe.wr && w_ptr[0] && (w_ptr[9:8] == 2'b00);  // High half completes

  // ----------------------------------------
  // Word pointers
  // ----------------------------------------
  always_ff @(posedge ti_clk)
  begin
    if (adjust_reset || i_ptr_clear)
    begin
      w_ptr <= '0;
      r_ptr <= '0;
    end
    else
    begin
      if (i_pipe.wr)
        w_ptr <= w_ptr + 1'b1;
      if (i_pipe.rd)
        r_ptr <= r_ptr + 1'b1;
    end
  end

  always_ff @(posedge ti_clk)
  begin
    if (i_pipe.wr && !w_ptr[0])   // Even slot, low half comes first
      low_store <= i_pipe.data;
  end

  // ----------------------------------------
  // Register commit
  // ----------------------------------------
  always_ff @(posedge ti_clk)
  begin
    if (adjust_reset)
    begin
      control <= '0;                 // Supplies on, counter running
      length  <= LENGTH_RST;
      divider <= DIVIDER_RST;
      for (int i = 0; i < 8; i++)
        segment[i] <= SEGMENT_RST[i];
    end
    else if (wr_commit)
    begin
      case (wr_idx)
        REG_CONTROL: control <= wr_value;
        REG_LENGTH:  length  <= wr_value;
        REG_DIVIDER: divider <= wr_value;
        REG_SEGMENT1, REG_SEGMENT2, REG_SEGMENT3, REG_SEGMENT4,
        REG_SEGMENT5, REG_SEGMENT6, REG_SEGMENT7, REG_SEGMENT8:
          segment[wr_idx[2:0]] <= wr_value;
        default: ;                   // Status, version, bursts and holes drop the write
      endcase
    end
  end

  // ----------------------------------------
  // Read image, two stages to the pipe
  // ----------------------------------------
  always_ff @(posedge ti_clk)
  begin
    rd_half <= r_ptr[0];
    if (r_ptr[9:8] != 2'b00)
      rd_image <= RD_DEFAULT;        // Outside the bank
    else
      case (rd_idx)
        REG_STATUS:  rd_image <= {i_rd_count, i_wr_count};
        REG_CONTROL: rd_image <= control;
        REG_VERSION: rd_image <= FPGA_VERSION;
        REG_LENGTH:  rd_image <= length;
        REG_DIVIDER: rd_image <= divider;
        REG_BURSTS:  rd_image <= i_bursts;  // Completed four word bursts
        REG_SEGMENT1, REG_SEGMENT2, REG_SEGMENT3, REG_SEGMENT4,
        REG_SEGMENT5, REG_SEGMENT6, REG_SEGMENT7, REG_SEGMENT8:
          rd_image <= segment[rd_idx[2:0]];
        default:     rd_image <= RD_DEFAULT;
      endcase
    o_rd_data <= rd_half ? rd_image[15:0] : rd_image[31:16];  // High half on even slots
  end

  assign o_shutdown    = control[0];
  assign o_burst_clear = control[1];

  // All rails follow the shutdown bit
  assign o_supply.vssn_en    = !o_shutdown;
  assign o_supply.vss22n_en  = !o_shutdown;
  assign o_supply.vdd_en     = !o_shutdown;
  assign o_supply.vdd15_en   = !o_shutdown;
  assign o_supply.vdd22_en   = !o_shutdown;
  assign o_supply.vdd18_en_n = o_shutdown;   // Active low
  assign o_supply.vtt_en     = !o_shutdown;

endmodule

`default_nettype wire

/* hw/spi_burst_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_burst_ctrl #(
  parameter int PACE_BITS       = 7,
  parameter int WORDS_PER_BURST = 4
) (
  input  wire             ti_clk,
  input  wire             adjust_reset,
  input  wire             i_fifo_empty,
  input  wire             i_master_busy,
  input  wire             i_word_done,    // rx_valid from the master
  input  wire             i_burst_clear,
  output logic            o_start,
  output logic            o_pop,
  output logic            o_cs_n,
  output clio_pkg::reg_t  o_bursts
);
  import clio_pkg::*;

  localparam int WC_W = (WORDS_PER_BURST > 1) ? $clog2(WORDS_PER_BURST) : 1;

  logic [PACE_BITS-1:0] pace_cnt;   // Free running start pacer
  logic [WC_W-1:0]      word_cnt;   // Words finished in this burst
  logic                 last_word;

  assign o_start   = (pace_cnt == '0) && !i_fifo_empty && !i_master_busy;
  assign last_word = (word_cnt == WC_W'(WORDS_PER_BURST - 1));

  // ----------------------------------------
  // Pacer and FIFO pop
  // ----------------------------------------
  always_ff @(posedge ti_clk)
  begin
    if (adjust_reset)
    begin
      pace_cnt <= '0;
      o_pop    <= 1'b0;
    end
    else
    begin
      o_pop <= o_start;                 // Head already latched by the master
      if (!o_pop)
        pace_cnt <= pace_cnt + 1'b1;    // Stalls one cycle per pop
    end
  end

  // ----------------------------------------
  // Chip select and burst count
  // ----------------------------------------
  always_ff @(posedge ti_clk)
  begin
    if (adjust_reset)
    begin
      word_cnt <= '0;
      o_cs_n   <= 1'b1;
      o_bursts <= '0;
    end
    else
    begin
      if (o_start)
        o_cs_n <= 1'b0;                 // Low from the first word
      if (i_word_done)
      begin
        if (last_word || i_fifo_empty)  // Full burst or nothing left
        begin
          word_cnt <= '0;
          o_cs_n   <= 1'b1;
        end
        else
          word_cnt <= word_cnt + 1'b1;
      end
      if (i_burst_clear)
        o_bursts <= '0;                 // Held at zero while the bit is set
      else if (i_word_done && last_word)
        o_bursts <= o_bursts + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* hw/spi_word_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_word_fifo #(
  parameter int DEPTH_LOG2 = 6
) (
  input  wire                   ti_clk,
  input  wire                   adjust_reset,
  input  wire                   i_push,
  input  wire clio_pkg::word_t  i_push_data,
  input  wire                   i_pop,
  output clio_pkg::word_t       o_head,      // Show-ahead, valid while not empty
  output logic                  o_empty,
  output clio_pkg::fifo_count_t o_count
);
  import clio_pkg::*;

  localparam int DEPTH = 2 ** DEPTH_LOG2;

  word_t                 mem [DEPTH];
  logic [DEPTH_LOG2-1:0] wr_ptr;
  logic [DEPTH_LOG2-1:0] rd_ptr;
  logic [DEPTH_LOG2:0]   count;      // One extra bit to tell full from empty
  logic                  do_push;
  logic                  do_pop;

  assign do_pop  = i_pop && (count != '0);                          // Empty pop ignored
  assign do_push = i_push && (count != (DEPTH_LOG2 + 1)'(DEPTH));  // Full push dropped

  always_ff @(posedge ti_clk)
  begin
    if (do_push)
      mem[wr_ptr] <= i_push_data;
  end

  always_ff @(posedge ti_clk)
  begin
    if (adjust_reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;   // Wraps at DEPTH
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;                 // Both or neither, level unchanged
      endcase
    end
  end

  assign o_head  = mem[rd_ptr];
  assign o_empty = (count == '0);
  assign o_count = fifo_count_t'(count);

endmodule

`default_nettype wire

/* hw/spi_word_master.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_word_master #(
  parameter int SCLK_HALF = 2   // ti_clk cycles per SCLK half period
) (
  input  wire                  ti_clk,
  input  wire                  adjust_reset,
  input  wire                  i_start,
  input  wire clio_pkg::word_t i_tx_word,
  input  wire                  i_spi_miso,
  input  wire                  i_cs_n,
  input  wire                  i_shutdown,
  output logic                 o_busy,
  output logic                 o_rx_valid,
  output clio_pkg::word_t      o_rx_word,
  output logic                 o_spi_sclk,
  output logic                 o_spi_mosi,
  output logic                 o_spi_cs_n
);
  import clio_pkg::*;

  localparam int DIV_W = (SCLK_HALF > 1) ? $clog2(SCLK_HALF) : 1;

  spi_state_e       state;
  logic [DIV_W-1:0] div_cnt;    // Position inside one SCLK half
  logic [3:0]       bit_cnt;    // Bits finished so far
  logic             sclk;
  logic             half_done;  // SCLK toggles on this edge
  word_t            tx_sr;
  word_t            rx_sr;

  assign half_done = (div_cnt == DIV_W'(SCLK_HALF - 1));

  // ----------------------------------------
  // Sequencing
  // ----------------------------------------
  always_ff @(posedge ti_clk)
  begin
    if (adjust_reset)
    begin
      state   <= SPI_IDLE;
      div_cnt <= '0;
      bit_cnt <= '0;
      sclk    <= 1'b0;   // Mode 0 idles low
    end
    else
    begin
      case (state)
        SPI_IDLE:
          if (i_start)
          begin
            state   <= SPI_SHIFT;
            div_cnt <= '0;
            bit_cnt <= '0;
          end
        SPI_SHIFT:
          if (half_done)
          begin
            div_cnt <= '0;
            sclk    <= !sclk;
            if (sclk)                        // Falling edge closes a bit
            begin
              bit_cnt <= bit_cnt + 1'b1;
              if (bit_cnt == 4'd15)
                state <= SPI_TAIL;
            end
          end
          else
            div_cnt <= div_cnt + 1'b1;
        SPI_TAIL: state <= SPI_IDLE;         // One cycle to hand off the word
        default:  state <= SPI_IDLE;
      endcase
    end
  end

  // Shift registers, MSB first
  always_ff @(posedge ti_clk)
  begin
    if (state == SPI_IDLE && i_start)
      tx_sr <= i_tx_word;                      // Show-ahead word taken at start
    else if (state == SPI_SHIFT && half_done && sclk)
      tx_sr <= {tx_sr[14:0], 1'b0};            // MOSI moves with SCLK falling
    if (state == SPI_SHIFT && half_done && !sclk)
      rx_sr <= {rx_sr[14:0], i_spi_miso};      // Sample with SCLK rising
  end

  assign o_busy     = (state != SPI_IDLE);
  assign o_rx_valid = (state == SPI_TAIL);
  assign o_rx_word  = rx_sr;

  // Lines pulled low while the supplies are off, avoids back powering the chip
  assign o_spi_sclk = sclk && !i_shutdown;
  assign o_spi_mosi = (state == SPI_SHIFT) && tx_sr[15] && !i_shutdown;
  assign o_spi_cs_n = i_cs_n && !i_shutdown;

endmodule

`default_nettype wire

/* tb.f */
hw/clio_pkg.sv
hw/spi_word_fifo.sv
hw/spi_word_master.sv
hw/spi_burst_ctrl.sv
hw/clio_reg_bank.sv
hw/clio_ctrl_top.sv
testbench/tb_clk_gen.sv
testbench/tb_clio_ctrl.sv

/* testbench/tb_clio_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clio_ctrl;
  import clio_pkg::*;

  localparam int FIFO_DEPTH_LOG2 = 6;
  localparam int SCLK_HALF       = 2;
  localparam int PACE_BITS       = 7;
  localparam int WORDS_PER_BURST = 4;
  localparam int MAX_N1          = 23;                    // 8 plus four random bits
  localparam int MAX_N2          = 19;                    // 4k + r, k up to 4
  localparam int SPI_CYCLES      = 32 * SCLK_HALF + 2;    // Shift plus tail
  localparam int PACE_CYCLES     = 2 ** PACE_BITS + 1;    // Wrap plus pop stall
  localparam int WORD_CYCLES     = (PACE_CYCLES > SPI_CYCLES) ? PACE_CYCLES : SPI_CYCLES;
  localparam int CYCLE_LIMIT     = (MAX_N1 + MAX_N2) * WORD_CYCLES * 2 + 8000;

  logic        ti_clk;
  logic        adjust_reset;
  logic        reg_ptr_clear;
  pipe_in_t    reg_pipe;
  pipe_in_t    noz_pipe;
  logic        spi_miso;
  word_t       reg_rd_data;
  word_t       noz_rd_data;
  fifo_count_t noz_wr_count;
  fifo_count_t noz_rd_count;
  logic        spi_sclk;
  logic        spi_mosi;
  logic        spi_cs_n;
  supply_en_t  supply;

  // ----------------------------------------
  // Models and bookkeeping
  // ----------------------------------------
  reg_t        reg_model [17];     // Indices 0 to 16, one past the bank
  reg_t        bursts_model;
  word_t       sent_q [$];         // Words pushed, not yet popped
  word_t       mosi_q [$];         // Words seen on MOSI
  logic [31:0] lfsr_state;
  word_t       cap_sr;
  int          cap_bits;
  int          cs_rises;
  logic        count_rises;
  int          errors;
  int          checks;
  int          tests;
  int          errors_at_start;
  int          checks_at_start;
  int          cycles;

  tb_clk_gen #(.PERIOD_NS(40), .RESET_CYCLES(8)) clk_gen0 (
    .ti_clk       (ti_clk),
    .adjust_reset (adjust_reset)
  );

  assign spi_miso = ~spi_mosi;   // Loopback, received word is the inverse

  clio_ctrl_top #(
    .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2),
    .SCLK_HALF       (SCLK_HALF),
    .PACE_BITS       (PACE_BITS),
    .WORDS_PER_BURST (WORDS_PER_BURST)
  ) dut0 (
    .ti_clk          (ti_clk),
    .adjust_reset    (adjust_reset),
    .i_reg_ptr_clear (reg_ptr_clear),
    .i_reg_pipe      (reg_pipe),
    .i_noz_pipe      (noz_pipe),
    .i_spi_miso      (spi_miso),
    .o_reg_rd_data   (reg_rd_data),
    .o_noz_rd_data   (noz_rd_data),
    .o_noz_wr_count  (noz_wr_count),
    .o_noz_rd_count  (noz_rd_count),
    .o_spi_sclk      (spi_sclk),
    .o_spi_mosi      (spi_mosi),
    .o_spi_cs_n      (spi_cs_n),
    .o_supply        (supply)
  );

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v          = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);   // One step per bit
    end
    return v;
  endfunction

  function automatic bit is_writable(input int idx);
    return (idx == REG_CONTROL) || (idx == REG_LENGTH) || (idx == REG_DIVIDER) ||
           (idx >= REG_SEGMENT1 && idx <= REG_SEGMENT8);
  endfunction

  function automatic reg_t expected_reg(input int idx);
    if (idx == REG_STATUS)
      return {16'(sent_q.size()), 16'h0000};   // Write FIFO drained when the bank is read
    else if (idx == REG_VERSION)
      return FPGA_VERSION;
    else if (idx == REG_BURSTS)
      return bursts_model;
    else if (is_writable(idx))
      return reg_model[idx];
    else
      return RD_DEFAULT;
  endfunction

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------
  task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("MISMATCH %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_reg(input string name, input reg_t got, input reg_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("MISMATCH %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input fifo_count_t got,
                             input fifo_count_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("MISMATCH %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_supply(input string name, input supply_en_t got,
                              input supply_en_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("MISMATCH %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_line(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("MISMATCH %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("ERROR %s", msg);
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("[%0d] %s: %0d checks, %0d errors", tests, name,
             checks - checks_at_start, errors - errors_at_start);
    checks_at_start = checks;
    errors_at_start = errors;
  endtask

  // ----------------------------------------
  // Host pipe drivers
  // ----------------------------------------
  task automatic clear_pointers();
    @(posedge ti_clk);
    #2 reg_ptr_clear = 1'b1;
    @(posedge ti_clk);
    #2 reg_ptr_clear = 1'b0;
  endtask

  task automatic write_reg(input reg_t value);
    for (int h = 0; h < 2; h++)
    begin
      @(posedge ti_clk);
      #2;
      reg_pipe.wr   = 1'b1;
      reg_pipe.data = h ? value[31:16] : value[15:0];   // Low half first
      @(posedge ti_clk);
      #2 reg_pipe.wr = 1'b0;
    end
  endtask

  task automatic read_reg(input int idx, output reg_t value);
    clear_pointers();
    if (idx > 0)
    begin
      @(posedge ti_clk);
      #2 reg_pipe.rd = 1'b1;               // Skip to the word pair of idx
      repeat (2 * idx) @(posedge ti_clk);
      #2 reg_pipe.rd = 1'b0;
    end
    for (int h = 0; h < 2; h++)
    begin
      repeat (3) @(posedge ti_clk);        // Image, then output stage
      @(negedge ti_clk);
      if (h == 0)
        value[31:16] = reg_rd_data;        // High half comes back first
      else
        value[15:0] = reg_rd_data;
      @(posedge ti_clk);
      #2 reg_pipe.rd = 1'b1;
      @(posedge ti_clk);
      #2 reg_pipe.rd = 1'b0;
    end
  endtask

  task automatic check_reg_read(input int idx);
    reg_t got;
    read_reg(idx, got);
    check_reg($sformatf("reg %0d", idx), got, expected_reg(idx));
  endtask

  task automatic set_control(input reg_t value);
    clear_pointers();
    write_reg(take_bits(32));   // Lands on the status register, dropped
    write_reg(value);
    reg_model[REG_CONTROL] = value;
  endtask

  task automatic send_words(input int n);
    word_t w;
    for (int i = 0; i < n; i++)
    begin
      w = word_t'(take_bits(16));
      sent_q.push_back(w);
      @(posedge ti_clk);
      #2;
      noz_pipe.wr   = 1'b1;
      noz_pipe.data = w;
      @(posedge ti_clk);
      #2 noz_pipe.wr = 1'b0;
    end
    while (noz_rd_count != fifo_count_t'(n))   // Cycle limit guards this wait
      @(posedge ti_clk);
    @(negedge ti_clk);
    check_count("o_noz_wr_count", noz_wr_count, '0);
  endtask

  task automatic drain_and_check(input int n);
    word_t w;
    for (int i = 0; i < n; i++)
    begin
      w = sent_q.pop_front();
      @(negedge ti_clk);
      check_word("o_noz_rd_data", noz_rd_data, ~w);
      if (mosi_q.size() == 0)
        report_failure("fewer words seen on MOSI than were pushed");
      else
        check_word("o_spi_mosi word", mosi_q.pop_front(), w);
      @(posedge ti_clk);
      #2 noz_pipe.rd = 1'b1;
      @(posedge ti_clk);
      #2 noz_pipe.rd = 1'b0;
    end
    @(negedge ti_clk);
    check_count("o_noz_rd_count", noz_rd_count, '0);
    if (mosi_q.size() != 0)
      report_failure("more words seen on MOSI than were pushed");
  endtask

  task automatic send_during_shutdown();
    word_t w;
    w = word_t'(take_bits(16));
    @(posedge ti_clk);
    #2;
    noz_pipe.wr   = 1'b1;
    noz_pipe.data = w;
    @(posedge ti_clk);
    #2 noz_pipe.wr = 1'b0;
    while (noz_rd_count != fifo_count_t'(1))   // Master still runs with the lines gated
      @(posedge ti_clk);
    @(negedge ti_clk);
    check_word("o_noz_rd_data", noz_rd_data, 16'hFFFF);   // MOSI held low, MISO reads ones
    if (mosi_q.size() != 0)
      report_failure("SCLK toggled while the supplies were off");
    @(posedge ti_clk);
    #2 noz_pipe.rd = 1'b1;
    @(posedge ti_clk);
    #2 noz_pipe.rd = 1'b0;
  endtask

  // ----------------------------------------
  // Bus monitors and cycle limit
  // ----------------------------------------
  always @(posedge spi_sclk)
  begin
    if (spi_cs_n === 1'b0)                 // MOSI settled since the falling edge
    begin
      cap_sr = {cap_sr[14:0], spi_mosi};
      cap_bits++;
      if (cap_bits == 16)
      begin
        mosi_q.push_back(cap_sr);
        cap_bits = 0;
      end
    end
  end

  always @(posedge spi_cs_n)
  begin
    if (count_rises)
      cs_rises++;
  end

  always @(posedge ti_clk)
  begin
    cycles++;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("TIMEOUT after %0d cycles, the nozzle words never all came back", cycles);
      $display("test failed");
      $finish;
    end
  end

  initial
  begin
    int         n1;
    int         n2;
    int         k;
    int         r;
    int         max_rises;
    reg_t       rv;
    supply_en_t sup_on;
    supply_en_t sup_off;

    reg_ptr_clear   = 1'b0;
    reg_pipe        = '0;
    noz_pipe        = '0;
    lfsr_state      = 32'hcbe815ef;
    cap_sr          = '0;
    cap_bits        = 0;
    cs_rises        = 0;
    count_rises     = 1'b0;
    errors          = 0;
    checks          = 0;
    tests           = 0;
    errors_at_start = 0;
    checks_at_start = 0;
    cycles          = 0;
    bursts_model    = '0;
    sup_on          = 7'b111_1101;   // vdd18_en_n low means on
    sup_off         = 7'b000_0010;
    for (int i = 0; i <= 16; i++)
      reg_model[i] = RD_DEFAULT;
    reg_model[REG_CONTROL] = '0;
    reg_model[REG_LENGTH]  = LENGTH_RST;
    reg_model[REG_DIVIDER] = DIVIDER_RST;
    for (int i = 0; i < 8; i++)
      reg_model[REG_SEGMENT1 + i] = SEGMENT_RST[i];

    wait (adjust_reset === 1'b0);

    // Reset values, index 16 is past the bank
    @(negedge ti_clk);
    check_supply("o_supply", supply, sup_on);
    check_line("o_spi_sclk", spi_sclk, 1'b0);
    check_line("o_spi_cs_n", spi_cs_n, 1'b1);
    check_count("o_noz_wr_count", noz_wr_count, '0);
    check_count("o_noz_rd_count", noz_rd_count, '0);
    for (int i = 0; i <= 16; i++)
      check_reg_read(i);
    finish_test("reset values");

    // One sequential pass over the whole map
    clear_pointers();
    for (int i = 0; i <= 16; i++)
    begin
      rv = take_bits(32);
      if (i == REG_CONTROL)
        rv[1:0] = 2'b00;                   // Supplies stay on, counter runs
      write_reg(rv);
      if (is_writable(i))
        reg_model[i] = rv;
    end
    for (int i = 0; i <= 16; i++)
      check_reg_read(i);
    finish_test("register writes");

    set_control(32'h0000_0001);
    @(negedge ti_clk);
    check_supply("o_supply", supply, sup_off);
    check_line("o_spi_sclk", spi_sclk, 1'b0);
    check_line("o_spi_mosi", spi_mosi, 1'b0);
    check_line("o_spi_cs_n", spi_cs_n, 1'b0);
    send_during_shutdown();
    check_reg_read(REG_CONTROL);
    set_control(32'h0000_0000);
    @(negedge ti_clk);
    check_supply("o_supply", supply, sup_on);
    check_line("o_spi_cs_n", spi_cs_n, 1'b1);
    finish_test("supply control");

    count_rises = 1'b1;
    n1 = 8 + int'(take_bits(4));
    send_words(n1);
    bursts_model = bursts_model + reg_t'(n1 / WORDS_PER_BURST);
    check_reg_read(REG_STATUS);
    check_reg_read(REG_BURSTS);
    drain_and_check(n1);
    finish_test("spi loopback");

    set_control(32'h0000_0002);
    bursts_model = '0;
    check_reg_read(REG_BURSTS);
    set_control(32'h0000_0000);
    k  = 1 + int'(take_bits(2));
    r  = int'(take_bits(2));
    n2 = WORDS_PER_BURST * k + r;
    send_words(n2);
    bursts_model = reg_t'(k);
    check_reg_read(REG_BURSTS);
    drain_and_check(n2);
    max_rises = (n1 + 3) / 4 + (n2 + 3) / 4;
    if (cs_rises > max_rises)
      report_failure($sformatf("cs_n rose %0d times, at most %0d bursts were possible",
                               cs_rises, max_rises));
    set_control(32'h0000_0002);
    bursts_model = '0;
    check_reg_read(REG_BURSTS);
    set_control(32'h0000_0000);
    finish_test("bursts");

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 8
) (
  output logic ti_clk,
  output logic adjust_reset
);

  initial
  begin
    ti_clk = 1'b0;
    forever #(PERIOD_NS / 2) ti_clk = ~ti_clk;
  end

  initial
  begin
    adjust_reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge ti_clk);
    #2 adjust_reset = 1'b0;   // Released off the edge like every other input
  end

endmodule

`default_nettype wire
